// ==== filelist.f ====
rtl/dispatch_pkg.sv
rtl/issue_arbiter.sv
rtl/load_use_detect.sv
rtl/operand_select.sv
rtl/dispatch_reg.sv
rtl/dispatch_top.sv
tests/dispatch_checker.sv
tests/tb_dispatch.sv

// ==== rtl/dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

    localparam int XLEN       = 32;   // data and pc width
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;
    localparam int ALU_SEL_W  = 3;
    localparam int ISSUE_W    = 2;    // issue slots, also forwarding lanes per stage
    localparam int NUM_SRC    = 2;    // source operands per instruction

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;
    typedef logic [ALU_SEL_W-1:0]  alu_sel_t;

    localparam alu_sel_t ALU_SEL_LOAD_STORE = 3'd5;   // memory class

    localparam alu_op_t ALU_PCADDU12I = 8'h1c;

    // load class opcodes, sc.w counts since it returns a value from memory
    localparam alu_op_t ALU_LDB  = 8'h28;
    localparam alu_op_t ALU_LDH  = 8'h29;
    localparam alu_op_t ALU_LDW  = 8'h2a;
    localparam alu_op_t ALU_LDBU = 8'h2c;
    localparam alu_op_t ALU_LDHU = 8'h2d;
    localparam alu_op_t ALU_LLW  = 8'h20;
    localparam alu_op_t ALU_SCW  = 8'h21;

    function automatic logic is_load_op(input alu_op_t op);
        logic hit;
        case (op)
            ALU_LDB,
            ALU_LDH,
            ALU_LDW,
            ALU_LDBU,
            ALU_LDHU,
            ALU_LLW,
            ALU_SCW: hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dispatch_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_reg import dispatch_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 pause_i,
    input  logic                                 flush_i,
    input  logic      [ISSUE_W-1:0]              slot_sel_i,

    input  data_t     [ISSUE_W-1:0]              pc_i,
    input  alu_op_t   [ISSUE_W-1:0]              alu_op_i,
    input  alu_sel_t  [ISSUE_W-1:0]              alu_sel_i,
    input  logic      [ISSUE_W-1:0]              reg_write_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              reg_write_addr_i,
    input  data_t     [ISSUE_W-1:0][NUM_SRC-1:0] operand_i,

    output logic      [ISSUE_W-1:0]              issue_en_o,
    output logic      [ISSUE_W-1:0]              valid_o,
    output data_t     [ISSUE_W-1:0]              pc_o,
    output alu_op_t   [ISSUE_W-1:0]              alu_op_o,
    output alu_sel_t  [ISSUE_W-1:0]              alu_sel_o,
    output logic      [ISSUE_W-1:0]              reg_write_en_o,
    output reg_addr_t [ISSUE_W-1:0]              reg_write_addr_o,
    output data_t     [ISSUE_W-1:0][NUM_SRC-1:0] operand_o
);

    // decode only drops what really got into the register
    assign issue_en_o = pause_i ? '0 : slot_sel_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o          <= '0;
            pc_o             <= '0;
            alu_op_o         <= '0;
            alu_sel_o        <= '0;
            reg_write_en_o   <= '0;
            reg_write_addr_o <= '0;
            operand_o        <= '0;
        end else if (flush_i) begin    // flush wins over pause
            valid_o          <= '0;
            pc_o             <= '0;
            alu_op_o         <= '0;
            alu_sel_o        <= '0;
            reg_write_en_o   <= '0;
            reg_write_addr_o <= '0;
            operand_o        <= '0;
        end else if (!pause_i) begin
            for (int s = 0; s < ISSUE_W; s++) begin
                if (slot_sel_i[s]) begin
                    valid_o[s]          <= 1'b1;
                    pc_o[s]             <= pc_i[s];
                    alu_op_o[s]         <= alu_op_i[s];
                    alu_sel_o[s]        <= alu_sel_i[s];
                    reg_write_en_o[s]   <= reg_write_en_i[s];
                    reg_write_addr_o[s] <= reg_write_addr_i[s];
                    operand_o[s]        <= operand_i[s];
                end else begin
                    // unselected slot becomes a bubble
                    valid_o[s]          <= 1'b0;
                    pc_o[s]             <= '0;
                    alu_op_o[s]         <= '0;
                    alu_sel_o[s]        <= '0;
                    reg_write_en_o[s]   <= 1'b0;
                    reg_write_addr_o[s] <= '0;
                    operand_o[s]        <= '0;
                end
            end
        end
    end

    // a flushed instruction must never reach execute, not even under pause
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (valid_o == '0 && reg_write_en_o == '0)
    ) else $error("dispatch_reg: slot still valid after flush");

endmodule

`default_nettype wire

// ==== rtl/dispatch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_top import dispatch_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 pause_i,
    input  logic                                 flush_i,

    // decoded pair, index 0 is the older instruction
    input  data_t     [ISSUE_W-1:0]              pc_i,
    input  logic      [ISSUE_W-1:0]              valid_i,
    input  alu_op_t   [ISSUE_W-1:0]              alu_op_i,
    input  alu_sel_t  [ISSUE_W-1:0]              alu_sel_i,
    input  data_t     [ISSUE_W-1:0]              imm_i,
    input  logic      [ISSUE_W-1:0]              is_privilege_i,
    input  logic      [ISSUE_W-1:0]              is_cnt_i,
    input  logic      [ISSUE_W-1:0]              reg_write_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              reg_write_addr_i,

    input  logic      [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_en_i,
    input  reg_addr_t [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_addr_i,
    input  data_t     [ISSUE_W-1:0][NUM_SRC-1:0] regfile_data_i,

    // forwarding, one lane per slot of each later stage
    input  logic      [ISSUE_W-1:0]              ex_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              ex_fwd_addr_i,
    input  data_t     [ISSUE_W-1:0]              ex_fwd_data_i,
    input  logic      [ISSUE_W-1:0]              mem_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              mem_fwd_addr_i,
    input  data_t     [ISSUE_W-1:0]              mem_fwd_data_i,
    input  logic      [ISSUE_W-1:0]              wb_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              wb_fwd_addr_i,
    input  data_t     [ISSUE_W-1:0]              wb_fwd_data_i,
    input  alu_op_t   [ISSUE_W-1:0]              ex_alu_op_i,

    output logic      [ISSUE_W-1:0]              issue_en_o,
    output logic                                 stall_o,

    // to execute
    output logic      [ISSUE_W-1:0]              valid_o,
    output data_t     [ISSUE_W-1:0]              pc_o,
    output alu_op_t   [ISSUE_W-1:0]              alu_op_o,
    output alu_sel_t  [ISSUE_W-1:0]              alu_sel_o,
    output logic      [ISSUE_W-1:0]              reg_write_en_o,
    output reg_addr_t [ISSUE_W-1:0]              reg_write_addr_o,
    output data_t     [ISSUE_W-1:0][NUM_SRC-1:0] operand_o
);

    logic                                 hazard;     // load-use, stalls the pair
    logic  [ISSUE_W-1:0]                  slot_sel;
    data_t [ISSUE_W-1:0][NUM_SRC-1:0]     operand;

    assign stall_o = hazard;

    load_use_detect load_use_detect_inst (
        .ex_alu_op_i     (ex_alu_op_i),
        .ex_fwd_en_i     (ex_fwd_en_i),
        .ex_fwd_addr_i   (ex_fwd_addr_i),
        .reg_read_en_i   (reg_read_en_i),
        .reg_read_addr_i (reg_read_addr_i),
        .hazard_o        (hazard)
    );

    issue_arbiter issue_arbiter_inst (
        .valid_i          (valid_i),
        .alu_sel_i        (alu_sel_i),
        .is_privilege_i   (is_privilege_i),
        .is_cnt_i         (is_cnt_i),
        .reg_write_en_i   (reg_write_en_i),
        .reg_write_addr_i (reg_write_addr_i),
        .reg_read_en_i    (reg_read_en_i),
        .reg_read_addr_i  (reg_read_addr_i),
        .hazard_i         (hazard),
        .slot_sel_o       (slot_sel)
    );

    for (genvar s = 0; s < ISSUE_W; s++) begin : g_slot
        for (genvar r = 0; r < NUM_SRC; r++) begin : g_src
            operand_select operand_select_inst (
                .read_en_i      (reg_read_en_i[s][r]),
                .read_addr_i    (reg_read_addr_i[s][r]),
                .regfile_data_i (regfile_data_i[s][r]),
                .imm_i          (imm_i[s]),
                .pc_i           (pc_i[s]),
                .alu_op_i       (alu_op_i[s]),
                .ex_fwd_en_i    (ex_fwd_en_i),
                .ex_fwd_addr_i  (ex_fwd_addr_i),
                .ex_fwd_data_i  (ex_fwd_data_i),
                .mem_fwd_en_i   (mem_fwd_en_i),
                .mem_fwd_addr_i (mem_fwd_addr_i),
                .mem_fwd_data_i (mem_fwd_data_i),
                .wb_fwd_en_i    (wb_fwd_en_i),
                .wb_fwd_addr_i  (wb_fwd_addr_i),
                .wb_fwd_data_i  (wb_fwd_data_i),
                .operand_o      (operand[s][r])
            );
        end
    end

    dispatch_reg dispatch_reg_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .pause_i          (pause_i),
        .flush_i          (flush_i),
        .slot_sel_i       (slot_sel),
        .pc_i             (pc_i),
        .alu_op_i         (alu_op_i),
        .alu_sel_i        (alu_sel_i),
        .reg_write_en_i   (reg_write_en_i),
        .reg_write_addr_i (reg_write_addr_i),
        .operand_i        (operand),
        .issue_en_o       (issue_en_o),
        .valid_o          (valid_o),
        .pc_o             (pc_o),
        .alu_op_o         (alu_op_o),
        .alu_sel_o        (alu_sel_o),
        .reg_write_en_o   (reg_write_en_o),
        .reg_write_addr_o (reg_write_addr_o),
        .operand_o        (operand_o)
    );

endmodule

`default_nettype wire

// ==== rtl/issue_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter import dispatch_pkg::*; (
    input  logic      [ISSUE_W-1:0]              valid_i,
    input  alu_sel_t  [ISSUE_W-1:0]              alu_sel_i,
    input  logic      [ISSUE_W-1:0]              is_privilege_i,
    input  logic      [ISSUE_W-1:0]              is_cnt_i,
    input  logic      [ISSUE_W-1:0]              reg_write_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              reg_write_addr_i,
    input  logic      [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_en_i,
    input  reg_addr_t [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_addr_i,
    input  logic                                 hazard_i,
    output logic      [ISSUE_W-1:0]              slot_sel_o
);

    logic mem_inst;    // a load or store in the pair
    logic priv_inst;
    logic cnt_inst;
    logic raw_pair;    // younger reads what older writes
    logic dual_ok;

    assign mem_inst  = (alu_sel_i[0] == ALU_SEL_LOAD_STORE) ||
                       (alu_sel_i[1] == ALU_SEL_LOAD_STORE);
    assign priv_inst = |is_privilege_i;
    assign cnt_inst  = |is_cnt_i;

    // r0 writes are discarded, so they never create a dependency
    always_comb begin
        raw_pair = 1'b0;
        if (reg_write_en_i[0] && reg_write_addr_i[0] != '0) begin
            for (int r = 0; r < NUM_SRC; r++) begin
                if (reg_read_en_i[1][r] && reg_read_addr_i[1][r] == reg_write_addr_i[0]) begin
                    raw_pair = 1'b1;
                end
            end
        end
    end

    assign dual_ok = (&valid_i) && !mem_inst && !priv_inst && !cnt_inst && !raw_pair;

    always_comb begin
        if (hazard_i) begin
            slot_sel_o = '0;              // load-use bubble
        end else if (dual_ok) begin
            slot_sel_o = 2'b11;
        end else if (valid_i[0]) begin
            slot_sel_o = 2'b01;           // older goes first
        end else if (valid_i[1]) begin
            slot_sel_o = 2'b10;
        end else begin
            slot_sel_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/load_use_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_use_detect import dispatch_pkg::*; (
    input  alu_op_t   [ISSUE_W-1:0]              ex_alu_op_i,
    input  logic      [ISSUE_W-1:0]              ex_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              ex_fwd_addr_i,
    input  logic      [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_en_i,
    input  reg_addr_t [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_addr_i,
    output logic                                 hazard_o
);

    logic [ISSUE_W-1:0] lane_load;   // lane holds a load that writes a real register

    always_comb begin
        hazard_o = 1'b0;
        for (int l = 0; l < ISSUE_W; l++) begin
            lane_load[l] = is_load_op(ex_alu_op_i[l]) && ex_fwd_en_i[l] &&
                           ex_fwd_addr_i[l] != '0;
            // each lane is checked against its own destination
            for (int s = 0; s < ISSUE_W; s++) begin
                for (int r = 0; r < NUM_SRC; r++) begin
                    if (lane_load[l] && reg_read_en_i[s][r] &&
                        reg_read_addr_i[s][r] == ex_fwd_addr_i[l]) begin
                        hazard_o = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select import dispatch_pkg::*; (
    input  logic                     read_en_i,
    input  reg_addr_t                read_addr_i,
    input  data_t                    regfile_data_i,
    input  data_t                    imm_i,
    input  data_t                    pc_i,
    input  alu_op_t                  alu_op_i,
    input  logic      [ISSUE_W-1:0] ex_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0] ex_fwd_addr_i,
    input  data_t     [ISSUE_W-1:0] ex_fwd_data_i,
    input  logic      [ISSUE_W-1:0] mem_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0] mem_fwd_addr_i,
    input  data_t     [ISSUE_W-1:0] mem_fwd_data_i,
    input  logic      [ISSUE_W-1:0] wb_fwd_en_i,
    input  reg_addr_t [ISSUE_W-1:0] wb_fwd_addr_i,
    input  data_t     [ISSUE_W-1:0] wb_fwd_data_i,
    output data_t                    operand_o
);

    // later lanes win, lane 1 is the younger instruction of its stage
    function automatic data_t fwd_pick(
        input data_t                    cur,
        input reg_addr_t                addr,
        input logic      [ISSUE_W-1:0] en,
        input reg_addr_t [ISSUE_W-1:0] waddr,
        input data_t     [ISSUE_W-1:0] wdata
    );
        data_t res;
        res = cur;
        for (int l = 0; l < ISSUE_W; l++) begin
            if (en[l] && waddr[l] == addr) begin
                res = wdata[l];
            end
        end
        return res;
    endfunction

    always_comb begin
        operand_o = read_en_i ? regfile_data_i : imm_i;
        if (read_en_i) begin
            // oldest stage first so the newest result ends up on top
            operand_o = fwd_pick(operand_o, read_addr_i, wb_fwd_en_i, wb_fwd_addr_i,
                                 wb_fwd_data_i);
            operand_o = fwd_pick(operand_o, read_addr_i, mem_fwd_en_i, mem_fwd_addr_i,
                                 mem_fwd_data_i);
            operand_o = fwd_pick(operand_o, read_addr_i, ex_fwd_en_i, ex_fwd_addr_i,
                                 ex_fwd_data_i);
            if (read_addr_i == '0) begin
                operand_o = '0;           // r0 is hardwired
            end
            // pcaddu12i reads the pc through its enabled source, imm stays on the other
            if (alu_op_i == ALU_PCADDU12I) begin
                operand_o = pc_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dispatch -f filelist.f || exit 1
out=$(./obj_dir/Vtb_dispatch)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1

// ==== tests/dispatch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_checker import dispatch_pkg::*; (
    input  logic                                 clk,
    input  logic                                 armed_i,
    input  int                                   test_id_i,
    input  logic      [ISSUE_W-1:0]              issue_en_i,
    input  logic      [ISSUE_W-1:0]              exp_issue_en_i,
    input  logic                                 stall_i,
    input  logic                                 exp_stall_i,
    input  logic      [ISSUE_W-1:0]              valid_i,
    input  logic      [ISSUE_W-1:0]              exp_valid_i,
    input  data_t     [ISSUE_W-1:0]              pc_i,
    input  data_t     [ISSUE_W-1:0]              exp_pc_i,
    input  alu_op_t   [ISSUE_W-1:0]              alu_op_i,
    input  alu_op_t   [ISSUE_W-1:0]              exp_alu_op_i,
    input  alu_sel_t  [ISSUE_W-1:0]              alu_sel_i,
    input  alu_sel_t  [ISSUE_W-1:0]              exp_alu_sel_i,
    input  logic      [ISSUE_W-1:0]              reg_write_en_i,
    input  logic      [ISSUE_W-1:0]              exp_reg_write_en_i,
    input  reg_addr_t [ISSUE_W-1:0]              reg_write_addr_i,
    input  reg_addr_t [ISSUE_W-1:0]              exp_reg_write_addr_i,
    input  data_t     [ISSUE_W-1:0][NUM_SRC-1:0] operand_i,
    input  data_t     [ISSUE_W-1:0][NUM_SRC-1:0] exp_operand_i,
    output int                                   err_cnt_o,
    output int                                   check_cnt_o
);

    int cur_test;
    int test_errs;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset";
            2: return "pairing";
            3: return "operand precedence";
            4: return "load-use";
            5: return "pause and flush";
            6: return "random mix";
            default: return "unknown";
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
        check_cnt_o++;
        if (got !== exp) begin
            err_cnt_o++;
            test_errs++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (test_id_i != cur_test) begin
            if (cur_test > 0)
                $display("test %0d %s finished with %0d errors", cur_test,
                         test_name(cur_test), test_errs);
            if (test_id_i > 6)
                $display("checks: %0d, errors: %0d", check_cnt_o, err_cnt_o);
            test_errs = 0;
            cur_test  = test_id_i;
        end
        if (armed_i) begin
            // inputs settled at the falling edge, so combinational outputs are stable here
            expect_eq("issue_en_o", 128'(issue_en_i), 128'(exp_issue_en_i));
            expect_eq("stall_o", 128'(stall_i), 128'(exp_stall_i));
            #1;
            expect_eq("valid_o", 128'(valid_i), 128'(exp_valid_i));
            expect_eq("pc_o", 128'(pc_i), 128'(exp_pc_i));
            expect_eq("alu_op_o", 128'(alu_op_i), 128'(exp_alu_op_i));
            expect_eq("alu_sel_o", 128'(alu_sel_i), 128'(exp_alu_sel_i));
            expect_eq("reg_write_en_o", 128'(reg_write_en_i), 128'(exp_reg_write_en_i));
            expect_eq("reg_write_addr_o", 128'(reg_write_addr_i), 128'(exp_reg_write_addr_i));
            expect_eq("operand_o", 128'(operand_i), 128'(exp_operand_i));
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch import dispatch_pkg::*; ();

    localparam int N_TESTS      = 6;
    localparam int CYC_PER_TEST = 400;   // longest test
    localparam int DONE_ID      = 7;

    localparam alu_op_t LOAD_OPS [7] = '{
        ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_LLW, ALU_SCW
    };

    logic clk;
    logic rst_n_i, pause_i, flush_i;
    data_t     [ISSUE_W-1:0]              pc_i, imm_i;
    logic      [ISSUE_W-1:0]              valid_i, is_privilege_i, is_cnt_i, reg_write_en_i;
    alu_op_t   [ISSUE_W-1:0]              alu_op_i, ex_alu_op_i;
    alu_sel_t  [ISSUE_W-1:0]              alu_sel_i;
    reg_addr_t [ISSUE_W-1:0]              reg_write_addr_i;
    logic      [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_en_i;
    reg_addr_t [ISSUE_W-1:0][NUM_SRC-1:0] reg_read_addr_i;
    data_t     [ISSUE_W-1:0][NUM_SRC-1:0] regfile_data_i;
    logic      [ISSUE_W-1:0]              ex_fwd_en_i, mem_fwd_en_i, wb_fwd_en_i;
    reg_addr_t [ISSUE_W-1:0]              ex_fwd_addr_i, mem_fwd_addr_i, wb_fwd_addr_i;
    data_t     [ISSUE_W-1:0]              ex_fwd_data_i, mem_fwd_data_i, wb_fwd_data_i;

    logic      [ISSUE_W-1:0]              issue_en_o, valid_o, reg_write_en_o;
    logic                                 stall_o;
    data_t     [ISSUE_W-1:0]              pc_o;
    alu_op_t   [ISSUE_W-1:0]              alu_op_o;
    alu_sel_t  [ISSUE_W-1:0]              alu_sel_o;
    reg_addr_t [ISSUE_W-1:0]              reg_write_addr_o;
    data_t     [ISSUE_W-1:0][NUM_SRC-1:0] operand_o;

    // expected next state of the register model
    logic      [ISSUE_W-1:0]              exp_issue, exp_valid, exp_we;
    logic                                 exp_stall;
    data_t     [ISSUE_W-1:0]              exp_pc;
    alu_op_t   [ISSUE_W-1:0]              exp_op;
    alu_sel_t  [ISSUE_W-1:0]              exp_sel;
    reg_addr_t [ISSUE_W-1:0]              exp_waddr;
    data_t     [ISSUE_W-1:0][NUM_SRC-1:0] exp_opnd;

    logic armed;
    int   test_id;
    int   err_cnt, check_cnt;

    dispatch_top dispatch_top_inst (.*);

    dispatch_checker dispatch_checker_inst (
        .clk (clk), .armed_i (armed), .test_id_i (test_id),
        .issue_en_i (issue_en_o), .exp_issue_en_i (exp_issue),
        .stall_i (stall_o), .exp_stall_i (exp_stall),
        .valid_i (valid_o), .exp_valid_i (exp_valid),
        .pc_i (pc_o), .exp_pc_i (exp_pc),
        .alu_op_i (alu_op_o), .exp_alu_op_i (exp_op),
        .alu_sel_i (alu_sel_o), .exp_alu_sel_i (exp_sel),
        .reg_write_en_i (reg_write_en_o), .exp_reg_write_en_i (exp_we),
        .reg_write_addr_i (reg_write_addr_o), .exp_reg_write_addr_i (exp_waddr),
        .operand_i (operand_o), .exp_operand_i (exp_opnd),
        .err_cnt_o (err_cnt), .check_cnt_o (check_cnt)
    );

    always #20 clk = ~clk;

    function automatic logic load_opcode(input alu_op_t op);
        return op inside {ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_LLW, ALU_SCW};
    endfunction

    // execute beats memory beats writeback and the younger lane wins within a stage
    function automatic data_t ref_operand(input int s, input int r);
        reg_addr_t a;
        data_t     v;
        logic      found;
        a = reg_read_addr_i[s][r];
        v = regfile_data_i[s][r];
        found = 1'b0;
        for (int l = ISSUE_W - 1; l >= 0; l--) begin
            if (!found && ex_fwd_en_i[l] && ex_fwd_addr_i[l] == a) begin
                v = ex_fwd_data_i[l];
                found = 1'b1;
            end
        end
        for (int l = ISSUE_W - 1; l >= 0; l--) begin
            if (!found && mem_fwd_en_i[l] && mem_fwd_addr_i[l] == a) begin
                v = mem_fwd_data_i[l];
                found = 1'b1;
            end
        end
        for (int l = ISSUE_W - 1; l >= 0; l--) begin
            if (!found && wb_fwd_en_i[l] && wb_fwd_addr_i[l] == a) begin
                v = wb_fwd_data_i[l];
                found = 1'b1;
            end
        end
        if (a == 0) v = '0;
        if (alu_op_i[s] == ALU_PCADDU12I) v = pc_i[s];
        if (!reg_read_en_i[s][r]) v = imm_i[s];
        return v;
    endfunction

    // exp_* hold the current register state on entry and the next state on return
    function automatic void ref_dispatch();
        logic       hz;
        logic       raw;
        logic       dual;
        logic [1:0] sel;
        hz = 1'b0;
        raw = 1'b0;
        for (int l = 0; l < ISSUE_W; l++) begin
            if (load_opcode(ex_alu_op_i[l]) && ex_fwd_en_i[l] && ex_fwd_addr_i[l] != 0) begin
                for (int s = 0; s < ISSUE_W; s++) begin
                    for (int r = 0; r < NUM_SRC; r++) begin
                        if (reg_read_en_i[s][r] && reg_read_addr_i[s][r] == ex_fwd_addr_i[l])
                            hz = 1'b1;
                    end
                end
            end
        end
        for (int r = 0; r < NUM_SRC; r++) begin
            if (reg_write_en_i[0] && reg_write_addr_i[0] != 0 && reg_read_en_i[1][r] &&
                reg_read_addr_i[1][r] == reg_write_addr_i[0])
                raw = 1'b1;
        end
        dual = valid_i == 2'b11 && alu_sel_i[0] != ALU_SEL_LOAD_STORE &&
               alu_sel_i[1] != ALU_SEL_LOAD_STORE && is_privilege_i == '0 &&
               is_cnt_i == '0 && !raw;
        if (hz) sel = 2'b00;
        else if (dual) sel = 2'b11;
        else if (valid_i[0]) sel = 2'b01;
        else if (valid_i[1]) sel = 2'b10;
        else sel = 2'b00;
        exp_issue = pause_i ? 2'b00 : sel;
        exp_stall = hz;
        for (int s = 0; s < ISSUE_W; s++) begin
            if (!rst_n_i || flush_i || (!pause_i && !sel[s])) begin
                exp_valid[s] = 1'b0;
                exp_pc[s]    = '0;
                exp_op[s]    = '0;
                exp_sel[s]   = '0;
                exp_we[s]    = 1'b0;
                exp_waddr[s] = '0;
                exp_opnd[s]  = '0;
            end else if (!pause_i) begin
                exp_valid[s] = 1'b1;
                exp_pc[s]    = pc_i[s];
                exp_op[s]    = alu_op_i[s];
                exp_sel[s]   = alu_sel_i[s];
                exp_we[s]    = reg_write_en_i[s];
                exp_waddr[s] = reg_write_addr_i[s];
                for (int r = 0; r < NUM_SRC; r++) exp_opnd[s][r] = ref_operand(s, r);
            end
        end
    endfunction

    task automatic rand_drive();
        for (int s = 0; s < ISSUE_W; s++) begin
            valid_i[s]          = ($urandom % 4) != 0;
            pc_i[s]             = $urandom;
            imm_i[s]            = $urandom;
            alu_op_i[s]         = alu_op_t'($urandom);
            alu_sel_i[s]        = alu_sel_t'($urandom);
            is_privilege_i[s]   = ($urandom % 8) == 0;
            is_cnt_i[s]         = ($urandom % 8) == 0;
            reg_write_en_i[s]   = 1'($urandom);
            reg_write_addr_i[s] = reg_addr_t'($urandom % 4);   // small set so addresses collide
            for (int r = 0; r < NUM_SRC; r++) begin
                reg_read_en_i[s][r]   = 1'($urandom);
                reg_read_addr_i[s][r] = reg_addr_t'($urandom % 4);
                regfile_data_i[s][r]  = $urandom;
            end
            ex_fwd_en_i[s]    = 1'($urandom);
            ex_fwd_addr_i[s]  = reg_addr_t'($urandom % 4);
            ex_fwd_data_i[s]  = $urandom;
            mem_fwd_en_i[s]   = 1'($urandom);
            mem_fwd_addr_i[s] = reg_addr_t'($urandom % 4);
            mem_fwd_data_i[s] = $urandom;
            wb_fwd_en_i[s]    = 1'($urandom);
            wb_fwd_addr_i[s]  = reg_addr_t'($urandom % 4);
            wb_fwd_data_i[s]  = $urandom;
            ex_alu_op_i[s]    = (($urandom % 4) == 0) ? LOAD_OPS[$urandom % 7] :
                                                        alu_op_t'($urandom);
        end
        rst_n_i = 1'b1;
        pause_i = ($urandom % 8) == 0;
        flush_i = ($urandom % 16) == 0;
    endtask

    // bends the random draw toward the behavior a test targets
    task automatic shape_inputs(input int id, input int i);
        int lane;
        int slot;
        if (id != 6) begin
            pause_i = 1'b0;
            flush_i = 1'b0;
        end
        case (id)
            1: begin
                rst_n_i = i >= 3;
                valid_i = '0;
            end
            2: begin
                ex_fwd_en_i    = '0;
                valid_i        = 2'b11;
                alu_sel_i      = '0;
                is_privilege_i = '0;
                is_cnt_i       = '0;
                reg_read_en_i[1] = '0;
                case (i % 7)
                    1: alu_sel_i[0] = ALU_SEL_LOAD_STORE;
                    2: is_privilege_i[1] = 1'b1;
                    3: is_cnt_i[0] = 1'b1;
                    4, 5: begin
                        reg_write_en_i[0]     = 1'b1;
                        reg_write_addr_i[0]   = (i % 7 == 4) ? 5'd2 : 5'd0;
                        reg_read_en_i[1][0]   = 1'b1;
                        reg_read_addr_i[1][0] = reg_write_addr_i[0];
                    end
                    6: valid_i = 2'b10;
                    default: ;
                endcase
            end
            3: begin
                ex_alu_op_i = '0;
                if (i % 3 == 0) alu_op_i[i % 2] = ALU_PCADDU12I;
            end
            4: begin
                lane = i % 2;
                slot = (i / 2) % 2;
                ex_alu_op_i[lane]        = LOAD_OPS[i % 7];
                ex_fwd_en_i[lane]        = 1'b1;
                ex_fwd_addr_i[lane]      = reg_addr_t'(1 + i % 3);
                reg_read_en_i[slot][0]   = 1'b1;
                reg_read_addr_i[slot][0] = ex_fwd_addr_i[lane];
            end
            5: begin
                pause_i = 1'($urandom);
                flush_i = ($urandom % 4) == 0;
            end
            default: ;
        endcase
    endtask

    task automatic run_test(input int id, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            test_id = id;
            rand_drive();
            shape_inputs(id, i);
            ref_dispatch();
            armed = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h7f01));
        clk = 1'b1;
        armed = 1'b0;
        test_id = 0;
        rst_n_i = 1'b0;
        rand_drive();
        rst_n_i = 1'b0;
        pause_i = 1'b0;
        flush_i = 1'b0;
        exp_valid = '0;
        exp_pc = '0;
        exp_op = '0;
        exp_sel = '0;
        exp_we = '0;
        exp_waddr = '0;
        exp_opnd = '0;
        exp_issue = '0;
        exp_stall = 1'b0;
        run_test(1, 8);
        run_test(2, 70);
        run_test(3, 60);
        run_test(4, 40);
        run_test(5, 60);
        run_test(6, CYC_PER_TEST);
        @(negedge clk);
        test_id = DONE_ID;
        armed = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((N_TESTS * CYC_PER_TEST + 20) * 40);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
